// ==== flist.f ====
gpif_pkg.sv
stream_fifo.sv
gpif_wr.sv
gpif_rd.sv
fifo_to_wb.sv
gpif_bridge.sv
gpif_bridge_props.sv
tb_gpif_bridge.sv

// ==== Bender.yml ====
package:
  name: gpif_bridge

sources:
  - gpif_pkg.sv
  - stream_fifo.sv
  - gpif_wr.sv
  - gpif_rd.sv
  - fifo_to_wb.sv
  - gpif_bridge.sv
  - target: test
    files:
      - gpif_bridge_props.sv
      - tb_gpif_bridge.sv

// ==== tb_gpif_bridge.sv ====
// Testbench for gpif_bridge with GPIF host driver, Wishbone slave model and stream checkers
`default_nettype none
`timescale 1ns/1ps

module tb_gpif_bridge;

   localparam int TXFIFOSIZE   = 3;
   localparam int RXFIFOSIZE   = 5;
   localparam int CTRLFIFOSIZE = 2;
   localparam int WAIT_LIMIT   = 4000;
   // Flag positions in gpif_rdy_o
   localparam int CF = 3;
   localparam int CE = 2;
   localparam int DF = 1;
   localparam int DE = 0;

   logic            gpif_clk;
   logic            arst_n_i;
   logic [15:0]     gpif_d_i;
   logic [15:0]     gpif_d_o;
   logic            gpif_wr_i;
   logic            gpif_rd_i;
   logic            gpif_ep_i;
   logic            gpif_eop_o;
   logic [3:0]      gpif_rdy_o;
   logic            clear_tx_i;
   logic            clear_rx_i;
   gpif_pkg::item_t tx_data_o;
   logic            tx_src_rdy_o;
   logic            tx_dst_rdy_i;
   gpif_pkg::item_t rx_data_i;
   logic            rx_src_rdy_i;
   logic            rx_dst_rdy_o;
   logic [15:0]     wb_adr_o;
   logic [15:0]     wb_dat_o;
   logic [15:0]     wb_dat_i;
   logic            wb_cyc_o;
   logic            wb_stb_o;
   logic            wb_we_o;
   logic            wb_ack_i;

   logic [31:0]     rng_host;
   logic [31:0]     rng_rdy;
   logic [31:0]     rng_slave;
   logic [31:0]     rdy_bits;
   logic [31:0]     slave_bits;
   logic [31:0]     skip_bits;
   int              tx_rdy_mode;
   logic            df_seen;
   gpif_pkg::item_t tx_exp[$];
   logic [15:0]     model_mem [16];
   logic [15:0]     slave_mem [16];
   int              ack_count;
   int              exp_acks;
   int              ack_wait;
   logic            wb_req;
   logic            req_we;
   logic [3:0]      req_adr;
   logic [15:0]     req_dat;

   gpif_bridge #(
      .TXFIFOSIZE(TXFIFOSIZE),
      .RXFIFOSIZE(RXFIFOSIZE),
      .CTRLFIFOSIZE(CTRLFIFOSIZE)
   ) dut_i (
      .gpif_clk(gpif_clk), .arst_n_i(arst_n_i),
      .gpif_d_i(gpif_d_i), .gpif_d_o(gpif_d_o), .gpif_wr_i(gpif_wr_i),
      .gpif_rd_i(gpif_rd_i), .gpif_ep_i(gpif_ep_i), .gpif_eop_o(gpif_eop_o),
      .gpif_rdy_o(gpif_rdy_o), .clear_tx_i(clear_tx_i), .clear_rx_i(clear_rx_i),
      .tx_data_o(tx_data_o), .tx_src_rdy_o(tx_src_rdy_o), .tx_dst_rdy_i(tx_dst_rdy_i),
      .rx_data_i(rx_data_i), .rx_src_rdy_i(rx_src_rdy_i), .rx_dst_rdy_o(rx_dst_rdy_o),
      .wb_adr_o(wb_adr_o), .wb_dat_o(wb_dat_o), .wb_dat_i(wb_dat_i),
      .wb_cyc_o(wb_cyc_o), .wb_stb_o(wb_stb_o), .wb_we_o(wb_we_o), .wb_ack_i(wb_ack_i)
   );

   initial gpif_clk = 1'b0;
   always #20 gpif_clk = ~gpif_clk;

   ////////////////////////////////////////////////////////////////////////////
   // Random numbers and checks

   // Fibonacci LFSR, taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic draw_bits(inout logic [31:0] state, input int n, output logic [31:0] value);
      value = '0;
      for (int i = 0; i < n; i++) begin
         state = lfsr_step(state);
         value = {value[30:0], state[0]};
      end
   endtask

   function automatic logic [15:0] fill_word(input logic [3:0] a);
      return {a, ~a, a ^ 4'h9, 4'h6};
   endfunction

   task automatic stop_with_failure(input string why);
      $display("%s", why);
      $display("TEST RESULT: FAIL");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_item(input gpif_pkg::item_t got, input gpif_pkg::item_t exp,
                             input string name);
      if (got !== exp) begin
         stop_with_failure($sformatf("mismatch at %0t ns: %s got %h expected %h",
                                     $time, name, got, exp));
      end
   endtask

   task automatic check_word(input logic [15:0] got, input logic [15:0] exp, input string name);
      if (got !== exp) begin
         stop_with_failure($sformatf("mismatch at %0t ns: %s got %h expected %h",
                                     $time, name, got, exp));
      end
   endtask

   task automatic check_flags(input logic [3:0] got, input logic [3:0] exp, input string name);
      if (got !== exp) begin
         stop_with_failure($sformatf("mismatch at %0t ns: %s got %b expected %b",
                                     $time, name, got, exp));
      end
   endtask

   task automatic check_bit(input logic got, input logic exp, input string name);
      if (got !== exp) begin
         stop_with_failure($sformatf("mismatch at %0t ns: %s got %b expected %b",
                                     $time, name, got, exp));
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // GPIF host driver

   // Waits for the endpoint's full flag to drop, then pulses gpif_wr_i once
   task automatic write_word(input logic ep, input logic [15:0] word);
      int waited;
      waited = 0;
      do begin
         @(negedge gpif_clk);
         waited++;
         if (waited > WAIT_LIMIT) stop_with_failure("timeout waiting for a full flag to clear");
      end while (ep ? gpif_rdy_o[CF] : gpif_rdy_o[DF]);
      @(posedge gpif_clk);
      gpif_ep_i <= ep;
      gpif_d_i  <= word;
      gpif_wr_i <= 1'b1;
      @(posedge gpif_clk);
      gpif_wr_i <= 1'b0;
   endtask

   // Word and EOP are sampled one cycle after the read pulse
   task automatic read_word(input logic ep, output logic [15:0] word, output logic eop);
      int waited;
      waited = 0;
      do begin
         @(negedge gpif_clk);
         waited++;
         if (waited > WAIT_LIMIT) stop_with_failure("timeout waiting for an empty flag to clear");
      end while (ep ? gpif_rdy_o[CE] : gpif_rdy_o[DE]);
      @(posedge gpif_clk);
      gpif_ep_i <= ep;
      gpif_rd_i <= 1'b1;
      @(posedge gpif_clk);
      gpif_rd_i <= 1'b0;
      @(negedge gpif_clk);
      word = gpif_d_o;
      eop  = gpif_eop_o;
   endtask

   task automatic send_tx_frame();
      logic [31:0]     r;
      int              len;
      gpif_pkg::item_t it;
      draw_bits(rng_host, 4, r);
      len = int'(r[3:0]) + 1;
      write_word(1'b0, 16'(len));
      for (int i = 0; i < len; i++) begin
         draw_bits(rng_host, 16, r);
         it                    = '0;
         it[15:0]              = r[15:0];
         it[gpif_pkg::SOF_BIT] = (i == 0);
         it[gpif_pkg::EOF_BIT] = (i == len - 1);
         tx_exp.push_back(it);
         write_word(1'b0, r[15:0]);
      end
   endtask

   task automatic drain_tx();
      int waited;
      waited = 0;
      while (tx_exp.size() != 0) begin
         @(negedge gpif_clk);
         waited++;
         if (waited > WAIT_LIMIT) stop_with_failure("timeout waiting for TX words to drain");
      end
      repeat (4) @(negedge gpif_clk);
      check_bit(tx_src_rdy_o, 1'b0, "tx_src_rdy_o");
   endtask

   // A batch of one to four commands, then all of their responses
   // Three or more back up the response FIFO and stall the engine
   task automatic run_command_batch();
      logic [31:0] r;
      logic [7:0]  op;
      logic [7:0]  tag;
      logic [15:0] adr;
      logic [15:0] dat;
      logic [15:0] word;
      logic [15:0] exp;
      logic        eop;
      logic [15:0] resp_exp[$];
      int          n;
      draw_bits(rng_host, 2, r);
      n = int'(r[1:0]) + 1;
      for (int c = 0; c < n; c++) begin
         draw_bits(rng_host, 2, r);
         case (r[1:0])
            2'd0:    op = gpif_pkg::CMD_READ;
            2'd3:    op = 8'h5c;
            default: op = gpif_pkg::CMD_WRITE;
         endcase
         draw_bits(rng_host, 8, r);
         tag = r[7:0];
         draw_bits(rng_host, 16, r);
         adr = r[15:0];
         draw_bits(rng_host, 16, r);
         dat = r[15:0];
         write_word(1'b1, {op, tag});
         write_word(1'b1, adr);
         write_word(1'b1, dat);
         if (op == gpif_pkg::CMD_WRITE) begin
            model_mem[adr[3:0]] = dat;
            resp_exp.push_back({op, tag});
            resp_exp.push_back(dat);
            exp_acks++;
         end else if (op == gpif_pkg::CMD_READ) begin
            resp_exp.push_back({op, tag});
            resp_exp.push_back(model_mem[adr[3:0]]);
            exp_acks++;
         end else begin
            resp_exp.push_back({8'(gpif_pkg::CMD_ERR), tag});
            resp_exp.push_back(16'h0000);
         end
      end
      for (int i = 0; i < 2 * n; i++) begin
         read_word(1'b1, word, eop);
         exp = resp_exp.pop_front();
         check_word(word, exp, "gpif_d_o");
         check_bit(eop, 1'(i % 2), "gpif_eop_o");
      end
      check_word(16'(ack_count), 16'(exp_acks), "wb_ack_i count");
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // RX stream source

   // Item is held until rx_dst_rdy_o takes it at the next rising edge
   task automatic push_rx_item(input gpif_pkg::item_t it);
      int waited;
      waited = 0;
      @(posedge gpif_clk);
      rx_data_i    <= it;
      rx_src_rdy_i <= 1'b1;
      do begin
         @(negedge gpif_clk);
         waited++;
         if (waited > WAIT_LIMIT) stop_with_failure("timeout waiting for rx_dst_rdy_o");
      end while (!rx_dst_rdy_o);
   endtask

   task automatic run_rx_round();
      logic [31:0]     r;
      int              nframes;
      int              len;
      gpif_pkg::item_t it;
      gpif_pkg::item_t exp;
      gpif_pkg::item_t rx_exp[$];
      logic [15:0]     word;
      logic            eop;
      draw_bits(rng_host, 2, r);
      nframes = int'(r[1:0]) + 1;
      for (int f = 0; f < nframes; f++) begin
         draw_bits(rng_host, 3, r);
         len = int'(r[2:0]) + 1;
         for (int i = 0; i < len; i++) begin
            draw_bits(rng_host, 16, r);
            it                    = '0;
            it[15:0]              = r[15:0];
            it[gpif_pkg::SOF_BIT] = (i == 0);
            it[gpif_pkg::EOF_BIT] = (i == len - 1);
            rx_exp.push_back(it);
            push_rx_item(it);
         end
      end
      @(posedge gpif_clk);
      rx_src_rdy_i <= 1'b0;
      while (rx_exp.size() != 0) begin
         exp = rx_exp.pop_front();
         read_word(1'b0, word, eop);
         check_word(word, exp[15:0], "gpif_d_o");
         check_bit(eop, exp[gpif_pkg::EOF_BIT], "gpif_eop_o");
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Stream sink, monitor and Wishbone slave

   // Mode 0 always ready, 1 half the time, 2 one cycle in eight
   always @(posedge gpif_clk) begin
      draw_bits(rng_rdy, 3, rdy_bits);
      case (tx_rdy_mode)
         0:       tx_dst_rdy_i <= 1'b1;
         1:       tx_dst_rdy_i <= rdy_bits[0];
         default: tx_dst_rdy_i <= (rdy_bits[2:0] == 3'd0);
      endcase
   end

   always @(negedge gpif_clk) begin
      if (arst_n_i) begin
         if (gpif_rdy_o[DF]) df_seen = 1'b1;
         if (tx_src_rdy_o && tx_dst_rdy_i) begin
            if (tx_exp.size() == 0) begin
               stop_with_failure("TX stream carried a word that was never written");
            end else begin
               check_item(tx_data_o, tx_exp.pop_front(), "tx_data_o");
            end
         end
      end
   end

   always @(negedge gpif_clk) begin
      wb_req  = arst_n_i && wb_cyc_o && wb_stb_o;
      req_we  = wb_we_o;
      req_adr = wb_adr_o[3:0];
      req_dat = wb_dat_o;
   end

   // Random ack delay of zero to three cycles
   always @(posedge gpif_clk) begin
      if (wb_ack_i) begin
         wb_ack_i <= 1'b0;
      end else if (wb_req) begin
         if (ack_wait == 0) begin
            wb_ack_i <= 1'b1;
            ack_count++;
            if (req_we) begin
               slave_mem[req_adr] = req_dat;
            end else begin
               wb_dat_i <= slave_mem[req_adr];
            end
            draw_bits(rng_slave, 2, slave_bits);
            ack_wait = int'(slave_bits[1:0]);
         end else begin
            ack_wait--;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Test sequence

   initial begin
      rng_host     = 32'he5bb;
      rng_rdy      = 32'he5bb;
      rng_slave    = 32'he5bb;
      draw_bits(rng_rdy, 11, skip_bits);
      draw_bits(rng_slave, 23, skip_bits);
      arst_n_i     = 1'b0;
      gpif_d_i     = '0;
      gpif_wr_i    = 1'b0;
      gpif_rd_i    = 1'b0;
      gpif_ep_i    = 1'b0;
      clear_tx_i   = 1'b0;
      clear_rx_i   = 1'b0;
      tx_dst_rdy_i = 1'b0;
      rx_data_i    = '0;
      rx_src_rdy_i = 1'b0;
      wb_dat_i     = '0;
      wb_ack_i     = 1'b0;
      wb_req       = 1'b0;
      tx_rdy_mode  = 0;
      df_seen      = 1'b0;
      ack_count    = 0;
      exp_acks     = 0;
      ack_wait     = 1;
      for (int i = 0; i < 16; i++) begin
         model_mem[i] = fill_word(4'(i));
         slave_mem[i] = fill_word(4'(i));
      end
      repeat (8) @(posedge gpif_clk);
      arst_n_i <= 1'b1;
      @(negedge gpif_clk);
      check_flags(gpif_rdy_o, 4'b0101, "gpif_rdy_o");
      check_bit(wb_cyc_o, 1'b0, "wb_cyc_o");
      check_bit(tx_src_rdy_o, 1'b0, "tx_src_rdy_o");

      // TX framing, then random and heavy back-pressure
      repeat (6) send_tx_frame();
      drain_tx();
      tx_rdy_mode = 1;
      repeat (6) send_tx_frame();
      drain_tx();
      tx_rdy_mode = 2;
      df_seen     = 1'b0;
      repeat (5) send_tx_frame();
      drain_tx();
      if (!df_seen) stop_with_failure("DF never rose while the TX sink was stalled");
      tx_rdy_mode = 0;

      repeat (10) run_command_batch();

      repeat (4) run_rx_round();
      @(negedge gpif_clk);
      check_flags(gpif_rdy_o, 4'b0101, "gpif_rdy_o");

      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

`default_nettype wire

// ==== gpif_bridge_props.sv ====
// Concurrent assertions on the Wishbone master and response stream of fifo_to_wb
`default_nettype none
`timescale 1ns/1ps

module gpif_bridge_props (
   input wire                  gpif_clk,
   input wire                  arst_n_i,
   input wire                  cyc_i,
   input wire                  stb_i,
   input wire [15:0]           adr_i,
   input wire                  ack_i,
   input wire gpif_pkg::item_t resp_data_i,
   input wire                  resp_src_rdy_i,
   input wire                  resp_dst_rdy_i
);

   // Strobe only inside a cycle
   stb_in_cyc: assert property (@(posedge gpif_clk) disable iff (!arst_n_i) stb_i |-> cyc_i)
      else $error("wb_stb_o high without wb_cyc_o");

   // Request held steady until the slave acks
   stb_held: assert property (@(posedge gpif_clk) disable iff (!arst_n_i)
      stb_i && !ack_i |=> stb_i && $stable(adr_i))
      else $error("wb_stb_o or wb_adr_o changed before wb_ack_i");

   // Offered response item stays until taken
   resp_held: assert property (@(posedge gpif_clk) disable iff (!arst_n_i)
      resp_src_rdy_i && !resp_dst_rdy_i |=> resp_src_rdy_i && $stable(resp_data_i))
      else $error("response item withdrawn before it was accepted");

endmodule

bind fifo_to_wb gpif_bridge_props props_i (
   .gpif_clk(gpif_clk), .arst_n_i(arst_n_i),
   .cyc_i(wb_cyc_o), .stb_i(wb_stb_o), .adr_i(wb_adr_o), .ack_i(wb_ack_i),
   .resp_data_i(data_o), .resp_src_rdy_i(src_rdy_o), .resp_dst_rdy_i(dst_rdy_i)
);

`default_nettype wire

// ==== gpif_bridge.sv ====
// Top level GPIF bridge with write side, read side, command engine and FIFOs
`default_nettype none
`timescale 1ns/1ps

module gpif_bridge #(
   parameter int TXFIFOSIZE   = 9,
   parameter int RXFIFOSIZE   = 9,
   parameter int CTRLFIFOSIZE = 5
) (
   input  wire              gpif_clk,
   input  wire              arst_n_i,
   // GPIF host side
   input  wire  [15:0]      gpif_d_i,
   output logic [15:0]      gpif_d_o,
   input  wire              gpif_wr_i,
   input  wire              gpif_rd_i,
   input  wire              gpif_ep_i,
   output logic             gpif_eop_o,
   output logic [3:0]       gpif_rdy_o,
   // System streams
   input  wire              clear_tx_i,
   input  wire              clear_rx_i,
   output gpif_pkg::item_t  tx_data_o,
   output logic             tx_src_rdy_o,
   input  wire              tx_dst_rdy_i,
   input  wire  gpif_pkg::item_t rx_data_i,
   input  wire              rx_src_rdy_i,
   output logic             rx_dst_rdy_o,
   // Wishbone master
   output logic [15:0]      wb_adr_o,
   output logic [15:0]      wb_dat_o,
   input  wire  [15:0]      wb_dat_i,
   output logic             wb_cyc_o,
   output logic             wb_stb_o,
   output logic             wb_we_o,
   input  wire              wb_ack_i
);

   logic cf, ce, df, de;

   gpif_pkg::item_t txw_data, ctrlw_data, ctrl_data, resp_in, resp_data, rx_data;
   logic txw_src_rdy, txw_dst_rdy, ctrlw_src_rdy, ctrlw_dst_rdy;
   logic ctrl_src_rdy, ctrl_dst_rdy, respin_src_rdy, respin_dst_rdy;
   logic resp_src_rdy, resp_dst_rdy, rx_src_rdy, rx_dst_rdy;

   // Host flag order
   assign gpif_rdy_o = {cf, ce, df, de};

   ////////////////////////////////////////////////////////////////////////////
   // TX and control write path

   gpif_wr u_gpif_wr (
      .gpif_clk(gpif_clk), .arst_n_i(arst_n_i),
      .gpif_d_i(gpif_d_i), .gpif_wr_i(gpif_wr_i), .gpif_ep_i(gpif_ep_i),
      .gpif_full_d_o(df), .gpif_full_c_o(cf),
      .data_o(txw_data), .src_rdy_o(txw_src_rdy), .dst_rdy_i(txw_dst_rdy),
      .ctrl_o(ctrlw_data), .ctrl_src_rdy_o(ctrlw_src_rdy), .ctrl_dst_rdy_i(ctrlw_dst_rdy));

   stream_fifo #(.SIZE(TXFIFOSIZE)) tx_fifo (
      .gpif_clk(gpif_clk), .arst_n_i(arst_n_i), .clear_i(clear_tx_i),
      .data_i(txw_data), .src_rdy_i(txw_src_rdy), .dst_rdy_o(txw_dst_rdy),
      .data_o(tx_data_o), .src_rdy_o(tx_src_rdy_o), .dst_rdy_i(tx_dst_rdy_i));

   stream_fifo #(.SIZE(CTRLFIFOSIZE)) ctrl_fifo (
      .gpif_clk(gpif_clk), .arst_n_i(arst_n_i), .clear_i(1'b0),
      .data_i(ctrlw_data), .src_rdy_i(ctrlw_src_rdy), .dst_rdy_o(ctrlw_dst_rdy),
      .data_o(ctrl_data), .src_rdy_o(ctrl_src_rdy), .dst_rdy_i(ctrl_dst_rdy));

   ////////////////////////////////////////////////////////////////////////////
   // Command engine

   fifo_to_wb u_fifo_to_wb (
      .gpif_clk(gpif_clk), .arst_n_i(arst_n_i),
      .data_i(ctrl_data), .src_rdy_i(ctrl_src_rdy), .dst_rdy_o(ctrl_dst_rdy),
      .data_o(resp_in), .src_rdy_o(respin_src_rdy), .dst_rdy_i(respin_dst_rdy),
      .wb_adr_o(wb_adr_o), .wb_dat_o(wb_dat_o), .wb_dat_i(wb_dat_i),
      .wb_cyc_o(wb_cyc_o), .wb_stb_o(wb_stb_o), .wb_we_o(wb_we_o), .wb_ack_i(wb_ack_i));

   stream_fifo #(.SIZE(CTRLFIFOSIZE)) resp_fifo (
      .gpif_clk(gpif_clk), .arst_n_i(arst_n_i), .clear_i(1'b0),
      .data_i(resp_in), .src_rdy_i(respin_src_rdy), .dst_rdy_o(respin_dst_rdy),
      .data_o(resp_data), .src_rdy_o(resp_src_rdy), .dst_rdy_i(resp_dst_rdy));

   ////////////////////////////////////////////////////////////////////////////
   // RX and response read path

   stream_fifo #(.SIZE(RXFIFOSIZE)) rx_fifo (
      .gpif_clk(gpif_clk), .arst_n_i(arst_n_i), .clear_i(clear_rx_i),
      .data_i(rx_data_i), .src_rdy_i(rx_src_rdy_i), .dst_rdy_o(rx_dst_rdy_o),
      .data_o(rx_data), .src_rdy_o(rx_src_rdy), .dst_rdy_i(rx_dst_rdy));

   gpif_rd u_gpif_rd (
      .gpif_clk(gpif_clk), .arst_n_i(arst_n_i),
      .gpif_rd_i(gpif_rd_i), .gpif_ep_i(gpif_ep_i),
      .gpif_d_o(gpif_d_o), .gpif_eop_o(gpif_eop_o),
      .gpif_empty_d_o(de), .gpif_empty_c_o(ce),
      .data_i(rx_data), .src_rdy_i(rx_src_rdy), .dst_rdy_o(rx_dst_rdy),
      .resp_i(resp_data), .resp_src_rdy_i(resp_src_rdy), .resp_dst_rdy_o(resp_dst_rdy));

endmodule

`default_nettype wire

// ==== fifo_to_wb.sv ====
// Command engine turning control frames into Wishbone cycles and response frames
`default_nettype none
`timescale 1ns/1ps

module fifo_to_wb (
   input  wire              gpif_clk,
   input  wire              arst_n_i,
   // Command stream in
   input  wire  gpif_pkg::item_t data_i,
   input  wire              src_rdy_i,
   output logic             dst_rdy_o,
   // Response stream out
   output gpif_pkg::item_t  data_o,
   output logic             src_rdy_o,
   input  wire              dst_rdy_i,
   // Wishbone master
   output logic [15:0]      wb_adr_o,
   output logic [15:0]      wb_dat_o,
   input  wire  [15:0]      wb_dat_i,
   output logic             wb_cyc_o,
   output logic             wb_stb_o,
   output logic             wb_we_o,
   input  wire              wb_ack_i
);

   typedef enum logic [2:0] {
      CMD_HDR,
      CMD_ADR,
      CMD_DAT,
      WB_CYCLE,
      RESP_HDR,
      RESP_DAT
   } state_e;

   state_e            state_q;
   gpif_pkg::cmd_op_e op_q;
   logic [7:0]        tag_q;
   logic [15:0]       adr_q;
   logic [15:0]       dat_q;
   logic              cmd_take;
   logic              resp_take;

   ////////////////////////////////////////////////////////////////////////////
   // Stream handshakes

   assign dst_rdy_o = (state_q == CMD_HDR) || (state_q == CMD_ADR) || (state_q == CMD_DAT);
   assign src_rdy_o = (state_q == RESP_HDR) || (state_q == RESP_DAT);

   assign cmd_take  = src_rdy_i & dst_rdy_o;
   assign resp_take = src_rdy_o & dst_rdy_i;

   always_comb begin
      data_o = '0;
      if (state_q == RESP_HDR) begin
         data_o[15:0]              = {op_q, tag_q};
         data_o[gpif_pkg::SOF_BIT] = 1'b1;
      end else begin
         data_o[15:0]              = dat_q;
         data_o[gpif_pkg::EOF_BIT] = 1'b1;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Wishbone master

   // Strobe and cycle share one lifetime, single beat only
   assign wb_cyc_o = (state_q == WB_CYCLE);
   assign wb_stb_o = wb_cyc_o;
   assign wb_we_o  = wb_cyc_o && (op_q == gpif_pkg::CMD_WRITE);
   assign wb_adr_o = adr_q;
   assign wb_dat_o = dat_q;

   ////////////////////////////////////////////////////////////////////////////
   // Command sequencing

   always_ff @(posedge gpif_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= CMD_HDR;
      end else begin
         case (state_q)
            // Words without SOF are stray and get dropped here
            CMD_HDR:  if (cmd_take && data_i[gpif_pkg::SOF_BIT]) state_q <= CMD_ADR;
            CMD_ADR:  if (cmd_take) state_q <= CMD_DAT;
            CMD_DAT: begin
               if (cmd_take) begin
                  if (op_q == gpif_pkg::CMD_READ || op_q == gpif_pkg::CMD_WRITE) begin
                     state_q <= WB_CYCLE;
                  end else begin
                     state_q <= RESP_HDR;
                  end
               end
            end
            WB_CYCLE: if (wb_ack_i) state_q <= RESP_HDR;
            RESP_HDR: if (resp_take) state_q <= RESP_DAT;
            RESP_DAT: if (resp_take) state_q <= CMD_HDR;
            default:  state_q <= CMD_HDR;
         endcase
      end
   end

   // Command fields, later reused for the response
   always_ff @(posedge gpif_clk) begin
      case (state_q)
         CMD_HDR: begin
            if (cmd_take) begin
               op_q  <= gpif_pkg::cmd_op_e'(data_i[15:8]);
               tag_q <= data_i[7:0];
            end
         end
         CMD_ADR: if (cmd_take) adr_q <= data_i[15:0];
         CMD_DAT: begin
            if (cmd_take) begin
               if (op_q == gpif_pkg::CMD_READ || op_q == gpif_pkg::CMD_WRITE) begin
                  dat_q <= data_i[15:0];
               end else begin
                  // Unknown opcode, answer with an error and zero data
                  op_q  <= gpif_pkg::CMD_ERR;
                  dat_q <= '0;
               end
            end
         end
         // Write data is echoed as is
         WB_CYCLE: if (wb_ack_i && !wb_we_o) dat_q <= wb_dat_i;
         default: ;
      endcase
   end

endmodule

`default_nettype wire

// ==== gpif_rd.sv ====
// GPIF read side popping RX or response words on host reads, with empty flags
`default_nettype none
`timescale 1ns/1ps

module gpif_rd (
   input  wire              gpif_clk,
   input  wire              arst_n_i,
   // Host read port
   input  wire              gpif_rd_i,
   input  wire              gpif_ep_i,
   output logic [15:0]      gpif_d_o,
   output logic             gpif_eop_o,
   output logic             gpif_empty_d_o,
   output logic             gpif_empty_c_o,
   // RX data stream in
   input  wire  gpif_pkg::item_t data_i,
   input  wire              src_rdy_i,
   output logic             dst_rdy_o,
   // Response stream in
   input  wire  gpif_pkg::item_t resp_i,
   input  wire              resp_src_rdy_i,
   output logic             resp_dst_rdy_o
);

   gpif_pkg::item_t sel_item;
   logic            pop_d;
   logic            pop_c;

   ////////////////////////////////////////////////////////////////////////////
   // Strobe decode

   // One read strobe pops exactly one word from the chosen endpoint
   assign dst_rdy_o      = gpif_rd_i & ~gpif_ep_i;
   assign resp_dst_rdy_o = gpif_rd_i & gpif_ep_i;

   assign pop_d = dst_rdy_o & src_rdy_i;
   assign pop_c = resp_dst_rdy_o & resp_src_rdy_i;

   assign sel_item = gpif_ep_i ? resp_i : data_i;

   // Flags follow the queue heads directly
   assign gpif_empty_d_o = ~src_rdy_i;
   assign gpif_empty_c_o = ~resp_src_rdy_i;

   ////////////////////////////////////////////////////////////////////////////
   // Output register

   // Word and EOP hold until the next successful read
   always_ff @(posedge gpif_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         gpif_d_o   <= '0;
         gpif_eop_o <= 1'b0;
      end else if (pop_d || pop_c) begin
         gpif_d_o   <= sel_item[15:0];
         gpif_eop_o <= sel_item[gpif_pkg::EOF_BIT];
      end
   end

endmodule

`default_nettype wire

// ==== gpif_wr.sv ====
// GPIF write side framing data and control words into streams, with full flags
`default_nettype none
`timescale 1ns/1ps

module gpif_wr (
   input  wire              gpif_clk,
   input  wire              arst_n_i,
   // Host write port
   input  wire  [15:0]      gpif_d_i,
   input  wire              gpif_wr_i,
   input  wire              gpif_ep_i,
   output logic             gpif_full_d_o,
   output logic             gpif_full_c_o,
   // Data stream out
   output gpif_pkg::item_t  data_o,
   output logic             src_rdy_o,
   input  wire              dst_rdy_i,
   // Control stream out
   output gpif_pkg::item_t  ctrl_o,
   output logic             ctrl_src_rdy_o,
   input  wire              ctrl_dst_rdy_i
);

   typedef enum logic {
      WAIT_LEN,
      PAYLOAD
   } state_e;

   state_e     state_q;
   logic [7:0] remain_q;
   logic       first_q;
   logic [1:0] cword_q;
   logic       wr_d;
   logic       wr_c;

   assign wr_d = gpif_wr_i & ~gpif_ep_i;
   assign wr_c = gpif_wr_i & gpif_ep_i;

   // Host must hold off while a flag is up
   assign gpif_full_d_o = ~dst_rdy_i;
   assign gpif_full_c_o = ~ctrl_dst_rdy_i;

   ////////////////////////////////////////////////////////////////////////////
   // Data endpoint

   // Length word is swallowed, only payload goes downstream
   assign src_rdy_o = wr_d & (state_q == PAYLOAD);

   always_comb begin
      data_o                     = '0;
      data_o[15:0]               = gpif_d_i;
      data_o[gpif_pkg::SOF_BIT]  = first_q;
      data_o[gpif_pkg::EOF_BIT]  = (remain_q == 8'd1);
   end

   always_ff @(posedge gpif_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q  <= WAIT_LEN;
         remain_q <= '0;
         first_q  <= 1'b0;
      end else begin
         case (state_q)
            WAIT_LEN: begin
               // Zero length carries no payload, so stay put
               if (wr_d && gpif_d_i[7:0] != 8'd0) begin
                  remain_q <= gpif_d_i[7:0];
                  first_q  <= 1'b1;
                  state_q  <= PAYLOAD;
               end
            end
            PAYLOAD: begin
               if (src_rdy_o && dst_rdy_i) begin
                  remain_q <= remain_q - 1'b1;
                  first_q  <= 1'b0;
                  if (remain_q == 8'd1) begin
                     state_q <= WAIT_LEN;
                  end
               end
            end
            default: state_q <= WAIT_LEN;
         endcase
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Control endpoint

   assign ctrl_src_rdy_o = wr_c;

   always_comb begin
      ctrl_o                     = '0;
      ctrl_o[15:0]               = gpif_d_i;
      ctrl_o[gpif_pkg::SOF_BIT]  = (cword_q == 2'd0);
      ctrl_o[gpif_pkg::EOF_BIT]  = (cword_q == 2'(gpif_pkg::CMD_WORDS - 1));
   end

   // Word position inside the current command
   always_ff @(posedge gpif_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         cword_q <= '0;
      end else if (wr_c && ctrl_dst_rdy_i) begin
         if (cword_q == 2'(gpif_pkg::CMD_WORDS - 1)) begin
            cword_q <= '0;
         end else begin
            cword_q <= cword_q + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== stream_fifo.sv ====
// Synchronous first-word-fall-through FIFO for stream items with clear
`default_nettype none
`timescale 1ns/1ps

module stream_fifo #(
   parameter int SIZE = 4
) (
   input  wire                    gpif_clk,
   input  wire                    arst_n_i,
   input  wire                    clear_i,
   // Write side
   input  wire  gpif_pkg::item_t  data_i,
   input  wire                    src_rdy_i,
   output logic                   dst_rdy_o,
   // Read side
   output gpif_pkg::item_t        data_o,
   output logic                   src_rdy_o,
   input  wire                    dst_rdy_i
);

   localparam int DEPTH = 2 ** SIZE;

   gpif_pkg::item_t mem [DEPTH];

   logic [SIZE-1:0] wr_ptr_q;
   logic [SIZE-1:0] rd_ptr_q;
   logic [SIZE:0]   count_q;
   logic            push;
   logic            pop;

   // Top count bit is set only when all DEPTH entries are taken
   assign dst_rdy_o = ~count_q[SIZE];
   assign src_rdy_o = |count_q;

   assign push = src_rdy_i & dst_rdy_o;
   assign pop  = src_rdy_o & dst_rdy_i;

   // Head of queue is always visible
   assign data_o = mem[rd_ptr_q];

   always_ff @(posedge gpif_clk) begin
      if (push) begin
         mem[wr_ptr_q] <= data_i;
      end
   end

   always_ff @(posedge gpif_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else if (clear_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         // Simultaneous push and pop leaves the count alone
         case ({push, pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== gpif_pkg.sv ====
// Shared stream item type, frame flag positions and command opcode enum
`default_nettype none

package gpif_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Stream items

   // 16-bit word plus frame flags in the two top bits
   typedef logic [17:0] item_t;

   // Start and end of frame markers inside item_t
   localparam int SOF_BIT = 16;
   localparam int EOF_BIT = 17;

   ////////////////////////////////////////////////////////////////////////////
   // Control endpoint commands

   // Words per command frame: header, address, write data
   localparam int CMD_WORDS = 3;

   // Opcode sits in the upper byte of the command header word
   typedef enum logic [7:0] {
      CMD_READ  = 8'h01,
      CMD_WRITE = 8'h02,
      // Response only, flags an opcode the engine does not know
      CMD_ERR   = 8'hff
   } cmd_op_e;

endpackage

`default_nettype wire
